// ==== tb/echo_trace.mem ====
// Header A5 0F LLLL: F bit0 corrupt FCS, bit1 short, bit2 back to back, LLLL bytes without FCS
// Then dst and src MAC in three words, first byte in the top bits, then a payload seed word
// Good, 64 bytes
a5000040
02aabbcc
dd010266
778899a1
3c5a1e07
// Good, 100 bytes
a5000064
0a0b0c0d
0e0f1011
12131415
9e3779b9
// Corrupt FCS, 64 bytes
a5010040
ffffffff
ffff0244
55667788
0badcafe
// Short, 40 bytes
a5020028
02000000
00010200
00000002
51f0a3c4
// Good, 72 bytes
a5000048
7c1e5a30
9b42c6d8
e1f20314
6d2b8e15
// Back to back with the one above, 64 bytes
a5040040
02ccddee
ff000244
33221100
c0ffee11
// Good, minimum length
a500003c
00112233
44556677
8899aabb
5a5aa5a5
// End of trace
00000000

// ==== sources.f ====
+incdir+include
design/eth_types_pkg.sv
design/eth_ctrl_pkg.sv
design/rgmii_nibble_rx.sv
design/frame_rx_check.sv
design/echo_buffer.sv
design/frame_tx_gen.sv
design/rgmii_nibble_tx.sv
design/marble_eth_echo.sv
tb/marble_eth_echo_sva.sv
tb/tb_marble_eth_echo.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Ethernet echo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
	--top-module tb_marble_eth_echo -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Test OK"

// ==== tb/tb_marble_eth_echo.sv ====
////////////////////////////////////////////////////////////
// Ethernet echo testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "marble_eth_params.svh"

module tb_marble_eth_echo;

	localparam int TRACE_WORDS = 64;
	localparam int WAIT_LIMIT  = 4000;
	localparam int HDR_BYTES   = `PREAMBLE_BYTES + 1;

	// Nibble table of the reflected CRC-32
	localparam logic [31:0] CRC_TBL [16] = '{
		32'h0000_0000, 32'h1db7_1064, 32'h3b6e_20c8, 32'h26d9_30ac,
		32'h76dc_4190, 32'h6b6b_51f4, 32'h4db2_6158, 32'h5005_713c,
		32'hedb8_8320, 32'hf00f_9344, 32'hd6d6_a3e8, 32'hcb61_b38c,
		32'h9b64_c2b0, 32'h86d3_d2d4, 32'ha00a_e278, 32'hbdbd_f21c
	};

	logic        tx_clk;
	logic        arst_n;
	logic [3:0]  rgmii_rxd;
	logic        rgmii_rx_ctl;
	wire  [3:0]  rgmii_txd;
	wire         rgmii_tx_ctl;
	wire  [15:0] rx_good_count;
	wire  [15:0] rx_bad_count;
	wire  [15:0] drop_count;

	logic [31:0] trace [TRACE_WORDS];
	logic [7:0]  frm [2048];
	logic [7:0]  exp_frame [2048];
	logic [7:0]  mon_bytes [2048];
	int          frm_len, exp_len, mon_len;
	int          errors, echoes, exp_echoes, exp_good, exp_bad, exp_drop;
	int          idle_nibs;
	bit          exp_pending, mon_active, mon_hi, seen_echo;
	bit          timed_out;
	logic [3:0]  mon_lo;
	integer      seed = 32'h97b7_592c;

	marble_eth_echo DUT (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.rgmii_rxd(rgmii_rxd), .rgmii_rx_ctl(rgmii_rx_ctl),
		.rgmii_txd(rgmii_txd), .rgmii_tx_ctl(rgmii_tx_ctl),
		.rx_good_count(rx_good_count), .rx_bad_count(rx_bad_count),
		.drop_count(drop_count)
	);

	bind marble_eth_echo marble_eth_echo_sva sva (
		.tx_clk(tx_clk), .arst_n(arst_n), .rgmii_tx_ctl(rgmii_tx_ctl), .byte_req(byte_req),
		.rx_good_count(rx_good_count), .rx_bad_count(rx_bad_count), .drop_count(drop_count)
	);

	always #2 tx_clk = !tx_clk;

	// Two table lookups per byte with the low nibble first
	function automatic logic [31:0] crc_add(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = CRC_TBL[c[3:0] ^ b[3:0]] ^ (c >> 4);
		r = CRC_TBL[r[3:0] ^ b[7:4]] ^ (r >> 4);
		return r;
	endfunction

	// Payload filler that depends on the whole byte index
	function automatic logic [7:0] payload_byte(input logic [31:0] fill_seed, input int idx);
		logic [15:0] k;
		k = 16'(idx);
		return (fill_seed[7:0] + k[7:0]) ^ (k[15:8] + fill_seed[15:8]);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		errors++;
		$display("mismatch %s got 0x%0h expected 0x%0h", name, got, want);
	endtask

	task automatic finish_run;
		$display("errors %0d, echoes %0d, good %0d, bad %0d, dropped %0d",
			errors, echoes, rx_good_count, rx_bad_count, drop_count);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge tx_clk);
		rgmii_rx_ctl <= 1'b1;
		rgmii_rxd    <= b[3:0];
		@(posedge tx_clk);
		rgmii_rxd    <= b[7:4];
	endtask

	// Preamble, SFD, frame bytes, FCS, then idle cycles
	task automatic send_frame(input bit corrupt, input int gap);
		logic [31:0] c;
		logic [31:0] fcs;
		int          flip;
		c = '1;
		repeat (`PREAMBLE_BYTES) send_byte(8'h55);
		send_byte(8'hd5);
		for (int i = 0; i < frm_len; i++) begin
			send_byte(frm[i]);
			c = crc_add(c, frm[i]);
		end
		fcs = ~c;
		if (corrupt) begin
			flip = int'($unsigned($random(seed)) % 32);
			fcs[flip] = !fcs[flip];
		end
		for (int k = 0; k < 4; k++)
			send_byte(fcs[8*k +: 8]);
		repeat (gap) begin
			@(posedge tx_clk);
			rgmii_rx_ctl <= 1'b0;
			rgmii_rxd    <= '0;
		end
	endtask

	task automatic check_counters;
		if (rx_good_count != 16'(exp_good))
			report_mismatch("rx_good_count", 32'(rx_good_count), 32'(exp_good));
		if (rx_bad_count != 16'(exp_bad))
			report_mismatch("rx_bad_count", 32'(rx_bad_count), 32'(exp_bad));
		if (drop_count != 16'(exp_drop))
			report_mismatch("drop_count", 32'(drop_count), 32'(exp_drop));
	endtask

	// Echoes and the counter total both have to catch up
	task automatic wait_outcomes(input string what);
		int n;
		n = 0;
		while ((echoes != exp_echoes ||
				int'(rx_good_count) + int'(rx_bad_count) + int'(drop_count) !=
				exp_good + exp_bad + exp_drop) && n < WAIT_LIMIT) begin
			@(posedge tx_clk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout while waiting for the outcome of %s", what);
		end else begin
			check_counters();
		end
	endtask

	task automatic check_echo;
		logic [31:0] c;
		logic [31:0] fcs;
		if (!exp_pending) begin
			errors++;
			$display("echo of %0d bytes arrived while no echo was expected", mon_len);
		end else if (mon_len != HDR_BYTES + exp_len + 4) begin
			report_mismatch("echo_len", 32'(mon_len), 32'(HDR_BYTES + exp_len + 4));
		end else begin
			for (int i = 0; i < `PREAMBLE_BYTES; i++)
				if (mon_bytes[i] != 8'h55)
					report_mismatch($sformatf("preamble[%0d]", i), 32'(mon_bytes[i]), 32'h55);
			if (mon_bytes[HDR_BYTES-1] != 8'hd5)
				report_mismatch("sfd", 32'(mon_bytes[HDR_BYTES-1]), 32'hd5);
			c = '1;
			for (int i = 0; i < exp_len; i++) begin
				if (mon_bytes[HDR_BYTES+i] != exp_frame[i])
					report_mismatch($sformatf("echo_byte[%0d]", i),
						32'(mon_bytes[HDR_BYTES+i]), 32'(exp_frame[i]));
				c = crc_add(c, exp_frame[i]);
			end
			// FCS goes out low byte first
			for (int k = 0; k < 4; k++)
				fcs[8*k +: 8] = mon_bytes[HDR_BYTES + exp_len + k];
			if (fcs != ~c)
				report_mismatch("echo_fcs", fcs, ~c);
		end
		exp_pending = 1'b0;
		echoes++;
	endtask

	// Rebuild transmitted bytes with the low nibble first after the rise of ctl
	always @(negedge tx_clk) begin
		if (arst_n && rgmii_tx_ctl) begin
			if (!mon_active) begin
				if (seen_echo && idle_nibs < 2 * `IFG_BYTES) begin
					errors++;
					$display("echo started after only %0d idle nibbles", idle_nibs);
				end
				mon_active = 1'b1;
				mon_hi     = 1'b0;
				mon_len    = 0;
			end
			if (!mon_hi) begin
				mon_lo = rgmii_txd;
			end else if (mon_len < 2048) begin
				mon_bytes[mon_len] = {rgmii_txd, mon_lo};
				mon_len++;
			end
			mon_hi    = !mon_hi;
			idle_nibs = 0;
		end else begin
			if (mon_active) begin
				mon_active = 1'b0;
				seen_echo  = 1'b1;
				check_echo();
			end
			idle_nibs++;
		end
	end

	initial begin
		logic [31:0] hdr;
		logic [31:0] c;
		string       check_str;
		int          ptr;
		int          gap;
		bit          next_b2b;
		tx_clk       = 1'b0;
		arst_n       = 1'b0;
		rgmii_rxd    = '0;
		rgmii_rx_ctl = 1'b0;
		errors       = 0;
		echoes       = 0;
		exp_echoes   = 0;
		exp_good     = 0;
		exp_bad      = 0;
		exp_drop     = 0;
		idle_nibs    = 0;
		exp_pending  = 1'b0;
		mon_active   = 1'b0;
		mon_hi       = 1'b0;
		seen_echo    = 1'b0;
		timed_out    = 1'b0;
		$readmemh("tb/echo_trace.mem", trace);

		// Reference CRC against the standard check value
		check_str = "123456789";
		c = '1;
		for (int i = 0; i < check_str.len(); i++)
			c = crc_add(c, check_str[i]);
		if (~c != 32'hcbf4_3926)
			report_mismatch("reference_crc", ~c, 32'hcbf4_3926);

		repeat (16) @(posedge tx_clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge tx_clk);
		check_counters();

		ptr = 0;
		while (ptr + 5 <= TRACE_WORDS && trace[ptr] != '0) begin
			hdr = trace[ptr];
			if (hdr[31:24] != 8'ha5) begin
				errors++;
				$display("trace word %0d is not a frame header", ptr);
				break;
			end
			frm_len = int'(hdr[15:0]);
			// Two MAC addresses with the first byte in the top bits
			for (int i = 0; i < 12; i++)
				frm[i] = trace[ptr + 1 + i/4][31 - 8*(i%4) -: 8];
			for (int i = 12; i < frm_len; i++)
				frm[i] = payload_byte(trace[ptr + 4], i);
			ptr += 5;

			if (hdr[18]) begin
				exp_drop++;
			end else if (hdr[16] || frm_len < `MIN_FRAME_BYTES) begin
				exp_bad++;
			end else begin
				// Echo comes back with the MAC addresses swapped
				for (int i = 0; i < frm_len; i++)
					exp_frame[i] = (i < 6) ? frm[i+6] : (i < 12) ? frm[i-6] : frm[i];
				exp_len     = frm_len;
				exp_pending = 1'b1;
				exp_good++;
				exp_echoes++;
			end

			// A back to back frame follows after the shortest gap
			next_b2b = ptr < TRACE_WORDS && trace[ptr][31:24] == 8'ha5 && trace[ptr][18];
			if (next_b2b)
				gap = 2 * `IFG_BYTES;
			else
				gap = 2 * `IFG_BYTES + int'($unsigned($random(seed)) % 32);
			send_frame(hdr[16], gap);
			if (!next_b2b)
				wait_outcomes($sformatf("frame at trace word %0d", ptr - 5));
			if (timed_out)
				break;
		end

		if (!timed_out) begin
			// Any late echo would show up on the quiet line
			repeat (400) @(posedge tx_clk);
			if (int'(rx_good_count) != echoes)
				report_mismatch("rx_good_count", 32'(rx_good_count), 32'(echoes));
			check_counters();
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== tb/marble_eth_echo_sva.sv ====
////////////////////////////////////////////////////////////
// Echo top timing assertions
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module marble_eth_echo_sva (
	input wire        tx_clk,
	input wire        arst_n,
	input wire        rgmii_tx_ctl,
	input wire        byte_req,
	input wire [15:0] rx_good_count,
	input wire [15:0] rx_bad_count,
	input wire [15:0] drop_count
);

	// No echo leaves the line before a good frame is counted
	tx_idle_after_reset: assert property (@(posedge tx_clk) disable iff (!arst_n)
		(rx_good_count == 16'd0) |-> !rgmii_tx_ctl)
		else $error("rgmii_tx_ctl high before any good frame");

	// One byte request every second cycle at most
	byte_req_spaced: assert property (@(posedge tx_clk) disable iff (!arst_n)
		byte_req |=> !byte_req)
		else $error("byte_req high on two cycles in a row");

	// Counters only move up
	good_count_rises: assert property (@(posedge tx_clk) disable iff (!arst_n)
		rx_good_count >= $past(rx_good_count))
		else $error("rx_good_count went down");

	bad_count_rises: assert property (@(posedge tx_clk) disable iff (!arst_n)
		rx_bad_count >= $past(rx_bad_count))
		else $error("rx_bad_count went down");

	drop_count_rises: assert property (@(posedge tx_clk) disable iff (!arst_n)
		drop_count >= $past(drop_count))
		else $error("drop_count went down");

endmodule

`default_nettype wire

// ==== design/marble_eth_echo.sv ====
////////////////////////////////////////////////////////////
// Marble 100 Mb/s Ethernet echo top
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module marble_eth_echo (
	input  wire         tx_clk,
	input  wire         arst_n,
	input  wire  [3:0]  rgmii_rxd,
	input  wire         rgmii_rx_ctl,
	output logic [3:0]  rgmii_txd,
	output logic        rgmii_tx_ctl,
	output logic [15:0] rx_good_count,
	output logic [15:0] rx_bad_count,
	output logic [15:0] drop_count
);
	import eth_types_pkg::*;

	// Receive side
	gmii_beat_t    rx_beat;
	frame_beat_t   rx_frame;
	frame_status_t rx_status;

	// Transmit side
	frame_beat_t   echo_beat;
	logic          payload_req;
	logic          frame_ready;
	logic [7:0]    tx_byte;
	logic          tx_en;
	logic          byte_req;

	rgmii_nibble_rx nibble_rx (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.rgmii_rxd(rgmii_rxd), .rgmii_rx_ctl(rgmii_rx_ctl),
		.rx_beat(rx_beat)
	);

	frame_rx_check rx_check (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.rx_beat(rx_beat), .frame(rx_frame), .status(rx_status)
	);

	echo_buffer echo (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.frame(rx_frame), .status(rx_status),
		.payload_req(payload_req), .payload(echo_beat), .frame_ready(frame_ready),
		.rx_good_count(rx_good_count), .rx_bad_count(rx_bad_count),
		.drop_count(drop_count)
	);

	frame_tx_gen tx_gen (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.frame_ready(frame_ready), .payload(echo_beat), .payload_req(payload_req),
		.byte_req(byte_req), .tx_byte(tx_byte), .tx_en(tx_en)
	);

	// Paces the whole transmit side
	rgmii_nibble_tx nibble_tx (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.tx_byte(tx_byte), .tx_en(tx_en), .byte_req(byte_req),
		.rgmii_txd(rgmii_txd), .rgmii_tx_ctl(rgmii_tx_ctl)
	);

endmodule

`default_nettype wire

// ==== design/rgmii_nibble_tx.sv ====
////////////////////////////////////////////////////////////
// RGMII transmit nibble splitter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rgmii_nibble_tx (
	input  wire        tx_clk,
	input  wire        arst_n,
	input  wire  [7:0] tx_byte,
	input  wire        tx_en,
	output logic       byte_req,
	output logic [3:0] rgmii_txd,
	output logic       rgmii_tx_ctl
);

	logic       phase;
	logic [3:0] hi;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			phase        <= 1'b0;
			hi           <= '0;
			byte_req     <= 1'b0;
			rgmii_txd    <= '0;
			rgmii_tx_ctl <= 1'b0;
		end else begin
			phase    <= !phase;
			byte_req <= 1'b0;
			if (!phase) begin
				// Low nibble first, ctl stays for both halves
				rgmii_txd    <= tx_byte[3:0];
				rgmii_tx_ctl <= tx_en;
				hi           <= tx_byte[7:4];
			end else begin
				rgmii_txd <= hi;
				// Framer updates on this pulse, sampled next even phase
				byte_req  <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/frame_tx_gen.sv ====
////////////////////////////////////////////////////////////
// Transmit framer with fresh FCS
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "marble_eth_params.svh"

module frame_tx_gen (
	input  wire                          tx_clk,
	input  wire                          arst_n,
	input  wire                          frame_ready,
	input  wire eth_types_pkg::frame_beat_t payload,
	output logic                         payload_req,
	input  wire                          byte_req,
	output logic [7:0]                   tx_byte,
	output logic                         tx_en
);
	import eth_types_pkg::*;
	import eth_ctrl_pkg::*;

	tx_state_e   state;
	logic [3:0]  cnt;
	logic [31:0] crc;
	logic [7:0]  nxt;
	logic        nxt_eof;
	logic        last_eof;

	// Fetch one byte ahead, the answer is latched before the next request
	assign payload_req = byte_req && (
		(state == TX_PREAMBLE && cnt == 4'(`PREAMBLE_BYTES)) ||
		((state == TX_SFD || state == TX_PAYLOAD) && !last_eof && !nxt_eof));

	// Prefetched payload byte
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			nxt     <= '0;
			nxt_eof <= 1'b0;
		end else if (payload.valid) begin
			nxt     <= payload.data;
			nxt_eof <= payload.eof;
		end
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= TX_IDLE;
			cnt      <= '0;
			crc      <= '1;
			last_eof <= 1'b0;
			tx_byte  <= '0;
			tx_en    <= 1'b0;
		end else if (byte_req) begin
			case (state)
			TX_IDLE: if (frame_ready) begin
				tx_byte <= 8'h55;
				tx_en   <= 1'b1;
				cnt     <= 4'd1;
				crc     <= '1;
				state   <= TX_PREAMBLE;
			end
			TX_PREAMBLE: if (cnt == 4'(`PREAMBLE_BYTES)) begin
				tx_byte  <= 8'hd5;
				last_eof <= 1'b0;
				state    <= TX_SFD;
			end else begin
				tx_byte <= 8'h55;
				cnt     <= cnt + 4'd1;
			end
			// SFD on the line behaves as a payload byte not yet at eof
			TX_SFD, TX_PAYLOAD: if (last_eof) begin
				// FCS goes out inverted, low byte first
				tx_byte <= ~crc[7:0];
				crc     <= {8'h00, crc[31:8]};
				cnt     <= 4'd1;
				state   <= TX_FCS;
			end else begin
				tx_byte  <= nxt;
				crc      <= crc32_step(crc, nxt);
				last_eof <= nxt_eof;
				state    <= TX_PAYLOAD;
			end
			TX_FCS: if (cnt == 4'd4) begin
				tx_en <= 1'b0;
				cnt   <= 4'd1;
				state <= TX_GAP;
			end else begin
				tx_byte <= ~crc[7:0];
				crc     <= {8'h00, crc[31:8]};
				cnt     <= cnt + 4'd1;
			end
			// Idle bytes, the exit byte counts as the last one
			TX_GAP: if (cnt == 4'(`IFG_BYTES - 1))
				state <= TX_IDLE;
			else
				cnt <= cnt + 4'd1;
			default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/echo_buffer.sv ====
////////////////////////////////////////////////////////////
// One frame echo store with MAC swap
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "marble_eth_params.svh"

module echo_buffer (
	input  wire                            tx_clk,
	input  wire                            arst_n,
	input  wire eth_types_pkg::frame_beat_t   frame,
	input  wire eth_types_pkg::frame_status_t status,
	input  wire                            payload_req,
	output eth_types_pkg::frame_beat_t     payload,
	output logic                           frame_ready,
	output logic [15:0]                    rx_good_count,
	output logic [15:0]                    rx_bad_count,
	output logic [15:0]                    drop_count
);
	import eth_ctrl_pkg::*;

	localparam logic [`BUF_AW:0] MAC_BYTES = 6;
	localparam logic [`BUF_AW:0] MAC_END   = 12;

	logic [7:0]       mem [2**`BUF_AW];
	echo_state_e      state;
	logic [`BUF_AW:0] wr_ptr, wr_addr, rd_ptr, rd_addr, frame_len;
	logic             wr_hit, wr_over, ovf, ovf_now, skip, rd_last;
	logic [7:0]       rd_data;
	logic             rd_valid, rd_sof, rd_eof;

	// sof always lands at address zero
	assign wr_addr = frame.sof ? '0 : wr_ptr;
	assign wr_hit  = (state == EB_FILL) && frame.valid;
	// Top address bit set means the store is full
	assign wr_over = wr_hit && wr_addr[`BUF_AW];
	assign ovf_now = ovf || wr_over;

	// Replay reads source MAC first, then destination
	always_comb begin
		if (rd_ptr < MAC_BYTES)
			rd_addr = rd_ptr + MAC_BYTES;
		else if (rd_ptr < MAC_END)
			rd_addr = rd_ptr - MAC_BYTES;
		else
			rd_addr = rd_ptr;
	end

	assign rd_last     = (rd_ptr == frame_len - 1'b1);
	assign frame_ready = (state == EB_REPLAY);
	assign payload     = '{data: rd_data, valid: rd_valid, sof: rd_sof, eof: rd_eof};

	always_ff @(posedge tx_clk) begin
		if (wr_hit && !wr_addr[`BUF_AW])
			mem[wr_addr[`BUF_AW-1:0]] <= frame.data;
		// Answer lands the cycle after the request
		if (payload_req)
			rd_data <= mem[rd_addr[`BUF_AW-1:0]];
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= EB_FILL;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			frame_len     <= '0;
			ovf           <= 1'b0;
			skip          <= 1'b0;
			rd_valid      <= 1'b0;
			rd_sof        <= 1'b0;
			rd_eof        <= 1'b0;
			rx_good_count <= '0;
			rx_bad_count  <= '0;
			drop_count    <= '0;
		end else begin
			rd_valid <= (state == EB_REPLAY) && payload_req;
			rd_sof   <= (rd_ptr == '0);
			rd_eof   <= rd_last;
			case (state)
			EB_FILL: begin
				if (frame.sof)
					ovf <= 1'b0;
				if (wr_over)
					ovf <= 1'b1;
				else if (wr_hit)
					wr_ptr <= wr_addr + 1'b1;
				if (status.valid) begin
					// Every verdict restarts the store
					wr_ptr <= '0;
					ovf    <= 1'b0;
					if (ovf_now) begin
						drop_count <= drop_count + 16'd1;
					end else if (status.good) begin
						rx_good_count <= rx_good_count + 16'd1;
						frame_len     <= status.len;
						rd_ptr        <= '0;
						state         <= EB_REPLAY;
					end else begin
						rx_bad_count <= rx_bad_count + 16'd1;
					end
				end
			end
			EB_REPLAY: begin
				// Frame arriving now is not stored
				if (frame.sof)
					skip <= 1'b1;
				if (status.valid) begin
					drop_count <= drop_count + 16'd1;
					skip       <= 1'b0;
				end
				if (payload_req) begin
					rd_ptr <= rd_ptr + 1'b1;
					if (rd_last)
						state <= ((skip || frame.sof) && !status.valid) ? EB_HOLD : EB_FILL;
				end
			end
			// Let the tail of the skipped frame pass
			EB_HOLD: if (status.valid) begin
				drop_count <= drop_count + 16'd1;
				skip       <= 1'b0;
				state      <= EB_FILL;
			end
			default: state <= EB_FILL;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/frame_rx_check.sv ====
////////////////////////////////////////////////////////////
// Receive framing, FCS strip and CRC check
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "marble_eth_params.svh"

module frame_rx_check (
	input  wire                          tx_clk,
	input  wire                          arst_n,
	input  wire eth_types_pkg::gmii_beat_t rx_beat,
	output eth_types_pkg::frame_beat_t   frame,
	output eth_types_pkg::frame_status_t status
);
	import eth_types_pkg::*;
	import eth_ctrl_pkg::*;

	// CRC register after a clean frame plus its FCS
	localparam logic [31:0] CRC_RESIDUE = 32'hdebb_20e3;

	rx_state_e        state;
	logic [2:0]       pre_cnt;
	logic             quiet;
	logic             frame_end;
	logic [3:0][7:0]  dly;
	logic [2:0]       fill;
	logic [7:0]       held;
	logic             held_v;
	logic             held_sof;
	logic             first;
	logic [31:0]      crc;
	logic [`BUF_AW:0] len;

	// Bytes come every second cycle, two quiet cycles end the frame
	assign frame_end = !rx_beat.dv && quiet;

	// Four byte delay line, the last four bytes are the FCS
	always_ff @(posedge tx_clk) begin
		if (rx_beat.dv)
			dly <= {dly[2:0], rx_beat.data};
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= RX_IDLE;
			pre_cnt  <= '0;
			quiet    <= 1'b1;
			fill     <= '0;
			held     <= '0;
			held_v   <= 1'b0;
			held_sof <= 1'b0;
			first    <= 1'b0;
			crc      <= '1;
			len      <= '0;
			frame    <= '0;
			status   <= '0;
		end else begin
			quiet  <= !rx_beat.dv;
			frame  <= '0;
			status <= '0;
			case (state)
			RX_IDLE: if (rx_beat.dv) begin
				pre_cnt <= 3'd1;
				state   <= (rx_beat.data == 8'h55) ? RX_PREAMBLE : RX_DRAIN;
			end
			RX_PREAMBLE: if (frame_end) begin
				state <= RX_IDLE;
			end else if (rx_beat.dv) begin
				if (rx_beat.data == 8'h55) begin
					// Saturate, longer preambles still lock
					if (pre_cnt != 3'(`PREAMBLE_BYTES))
						pre_cnt <= pre_cnt + 3'd1;
				end else if (rx_beat.data == 8'hd5 && pre_cnt == 3'(`PREAMBLE_BYTES)) begin
					state  <= RX_DATA;
					crc    <= '1;
					fill   <= '0;
					len    <= '0;
					held_v <= 1'b0;
					first  <= 1'b1;
				end else begin
					state <= RX_DRAIN;
				end
			end
			RX_DATA: if (frame_end) begin
				// Last held byte goes out with the verdict
				frame.data   <= held;
				frame.valid  <= held_v;
				frame.sof    <= held_sof;
				frame.eof    <= held_v;
				status.valid <= 1'b1;
				status.good  <= (crc == CRC_RESIDUE) &&
					(len >= (`BUF_AW+1)'(`MIN_FRAME_BYTES));
				status.len   <= len;
				state        <= RX_IDLE;
			end else if (rx_beat.dv) begin
				crc <= crc32_step(crc, rx_beat.data);
				if (fill != 3'd4) begin
					fill <= fill + 3'd1;
				end else begin
					// Release the previous byte, keep one back for eof
					frame.data  <= held;
					frame.valid <= held_v;
					frame.sof   <= held_sof;
					held        <= dly[3];
					held_v      <= 1'b1;
					held_sof    <= first;
					first       <= 1'b0;
					if (len != '1)
						len <= len + 1'b1;
				end
			end
			// Not a frame, wait for the line to go quiet
			RX_DRAIN: if (frame_end)
				state <= RX_IDLE;
			default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/rgmii_nibble_rx.sv ====
////////////////////////////////////////////////////////////
// RGMII receive nibble joiner
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rgmii_nibble_rx (
	input  wire                       tx_clk,
	input  wire                       arst_n,
	input  wire [3:0]                 rgmii_rxd,
	input  wire                       rgmii_rx_ctl,
	output eth_types_pkg::gmii_beat_t rx_beat
);

	logic       ctl_d;
	logic       phase;
	logic [3:0] lo;
	logic       take_lo;

	// Low nibble on the rise of ctl or on an even phase
	assign take_lo = rgmii_rx_ctl && (!ctl_d || !phase);

	// Held low nibble
	always_ff @(posedge tx_clk) begin
		if (take_lo)
			lo <= rgmii_rxd;
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctl_d   <= 1'b0;
			phase   <= 1'b0;
			rx_beat <= '0;
		end else begin
			ctl_d      <= rgmii_rx_ctl;
			rx_beat.dv <= 1'b0;
			if (take_lo) begin
				phase <= 1'b1;
			end else if (rgmii_rx_ctl) begin
				// Second nibble completes the byte, strobe next cycle
				rx_beat.data <= {rgmii_rxd, lo};
				rx_beat.dv   <= 1'b1;
				phase        <= 1'b0;
			end else begin
				phase <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/eth_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Ethernet echo FSM states
////////////////////////////////////////////////////////////
`default_nettype none

package eth_ctrl_pkg;

	// Receive checker
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_DATA,
		RX_DRAIN
	} rx_state_e;

	// Echo buffer
	typedef enum logic [1:0] {
		EB_FILL,
		EB_REPLAY,
		EB_HOLD
	} echo_state_e;

	// Transmit framer
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_PAYLOAD,
		TX_FCS,
		TX_GAP
	} tx_state_e;

endpackage

`default_nettype wire

// ==== design/eth_types_pkg.sv ====
////////////////////////////////////////////////////////////
// Ethernet byte stream types and CRC
////////////////////////////////////////////////////////////
`default_nettype none
`include "marble_eth_params.svh"

package eth_types_pkg;

	// One received byte with its strobe
	typedef struct packed {
		logic [7:0] data;
		logic       dv;
	} gmii_beat_t;

	// Frame byte with framing marks
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       sof;
		logic       eof;
	} frame_beat_t;

	// End of frame verdict, length excludes the FCS
	typedef struct packed {
		logic             valid;
		logic             good;
		logic [`BUF_AW:0] len;
	} frame_status_t;

	// Reflected CRC-32, one byte, LSB first
	function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			c = (c[0] ^ data[i]) ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== include/marble_eth_params.svh ====
////////////////////////////////////////////////////////////
// Ethernet echo sizes and limits
////////////////////////////////////////////////////////////
`ifndef MARBLE_ETH_PARAMS_SVH
`define MARBLE_ETH_PARAMS_SVH

// Echo buffer address width, one frame of up to 2048 bytes
`define BUF_AW 11

// Shortest accepted frame, counted after SFD and before FCS
`define MIN_FRAME_BYTES 60

// Count of 55 bytes ahead of the D5 SFD
`define PREAMBLE_BYTES 7

// Idle bytes between transmitted frames
`define IFG_BYTES 12

`endif
